// File: list.f
+incdir+include
rtl/vote_pkg.sv
rtl/vote_selector.sv
rtl/vote_adder_tree.sv
rtl/vote_counter.sv
rtl/vote_sequencer.sv
rtl/vote_top.sv
test/vote_properties.sv
test/vote_tb.sv

// File: run.sh
#!/bin/sh
# build and run the vote tally testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module vote_tb -o vote_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/vote_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "sim passed"; then
    exit 0
fi
echo "pass message not found"
exit 1

// File: test/vote_tb.sv
`timescale 1ns/1ns
`include "vote_params.svh"

module vote_tb;

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 10;
    // cycles allowed from the last strobe to done
    localparam int DONE_BOUND = `VOTE_PIPE_LAT + 10;
    // rough length of each test in cycles, summed for the watchdog
    localparam int TEST_CYCLES = 1 + 2 * (5 + DONE_BOUND) + (41 + DONE_BOUND)
                               + (16 + DONE_BOUND) + (3 + DONE_BOUND)
                               + (20 + `VOTE_PIPE_LAT + DONE_BOUND)
                               + (1 + DONE_BOUND) + 2;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + TEST_CYCLES + 100;

    logic                clk;
    logic                rst;
    logic                start;
    vote_pkg::round_t    rounds;
    vote_pkg::core_vec_t store;
    vote_pkg::core_vec_t core_result;
    logic                busy;
    logic                done;
    logic                decision;
    vote_pkg::sum_t      tally;

    int errors;
    int checks;
    // reference tally of the current window
    int model_sum;
    logic [31:0] lfsr_state;

    vote_top uut (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .rounds      (rounds),
        .store       (store),
        .core_result (core_result),
        .busy        (busy),
        .done        (done),
        .decision    (decision),
        .tally       (tally)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    // one lfsr step per bit taken
    task automatic random_vec(output vote_pkg::core_vec_t v);
        for (int i = 0; i < `VOTE_CORES; i++) begin
            v[i] = lfsr_state[0];
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    task automatic check_sum(input string test, input vote_pkg::sum_t expected,
                             input vote_pkg::sum_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error %s: expected %0d, actual %0d", test, expected, actual);
        end
    endtask

    task automatic check_bit(input string test, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error %s: expected %b, actual %b", test, expected, actual);
        end
    endtask

    // all tasks below start and end just after a falling edge
    task automatic drive_round(input vote_pkg::core_vec_t s, input vote_pkg::core_vec_t r,
                               input bit counted);
        store = s;
        core_result = r;
        // +1 per stored 1, -1 per stored 0, idle cores abstain
        if (counted) begin
            for (int i = 0; i < `VOTE_CORES; i++) begin
                if (s[i]) begin
                    model_sum = model_sum + (r[i] ? 1 : -1);
                end
            end
        end
        @(negedge clk);
    endtask

    task automatic idle(input int n);
        store = '0;
        core_result = '0;
        repeat (n) @(negedge clk);
    endtask

    // start pulse, model cleared along with the tally
    task automatic open_window(input int n);
        start = 1'b1;
        rounds = vote_pkg::round_t'(n);
        model_sum = 0;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic wait_done(input string test);
        int waited;
        waited = 0;
        store = '0;
        core_result = '0;
        while (!done && waited < DONE_BOUND) begin
            @(negedge clk);
            waited++;
        end
        if (!done) begin
            errors++;
            $display("%s: done did not arrive within %0d cycles", test, DONE_BOUND);
        end
    endtask

    // final tally, its sign and busy, all in the done cycle
    task automatic finish_window(input string test);
        wait_done(test);
        check_sum(test, vote_pkg::sum_t'(model_sum), tally);
        check_bit({test, "_decision"}, (model_sum < 0), decision);
        check_bit({test, "_busy"}, 1'b0, busy);
    endtask

    task automatic reset_state();
        check_bit("reset_busy", 1'b0, busy);
        check_bit("reset_done", 1'b0, done);
        check_bit("reset_decision", 1'b0, decision);
        check_sum("reset_tally", '0, tally);
    endtask

    // +64 then -64
    task automatic uniform_votes();
        open_window(4);
        repeat (4) drive_round('1, '1, 1'b1);
        finish_window("uniform_plus");
        open_window(4);
        repeat (4) drive_round('1, '0, 1'b1);
        finish_window("uniform_minus");
    endtask

    // back to back rounds, every cycle a round
    task automatic random_votes();
        vote_pkg::core_vec_t s;
        vote_pkg::core_vec_t r;
        open_window(40);
        repeat (40) begin
            random_vec(s);
            random_vec(r);
            // empty vector would not be a round
            if (s == '0) begin
                s[0] = 1'b1;
            end
            drive_round(s, r, 1'b1);
        end
        finish_window("random");
    endtask

    task automatic gapped_rounds();
        vote_pkg::core_vec_t s;
        vote_pkg::core_vec_t r;
        open_window(5);
        for (int k = 0; k < 5; k++) begin
            random_vec(s);
            random_vec(r);
            s[k] = 1'b1;
            // idle cycles so far must not have closed the window
            if (k == 4) begin
                check_bit("gaps_busy", 1'b1, busy);
            end
            drive_round(s, r, 1'b1);
            idle(1 + k % 3);
        end
        finish_window("gaps");
        // 8 up, 8 down, then one up and one down
        open_window(2);
        drive_round('1, 16'hff00, 1'b1);
        drive_round(16'h0003, 16'h0001, 1'b1);
        finish_window("tie");
    endtask

    task automatic strobes_outside_window();
        // idle sequencer drops these
        repeat (3) drive_round('1, '1, 1'b0);
        // long enough for a leaked strobe to reach the tally
        idle(`VOTE_PIPE_LAT);
        check_sum("before_start", vote_pkg::sum_t'(model_sum), tally);
        open_window(3);
        drive_round('1, 16'h00ff, 1'b1);
        // second start in mid window
        // a restart would keep the window open through the drain strobes
        start = 1'b1;
        rounds = vote_pkg::round_t'(8);
        drive_round(16'h0f0f, 16'h0f0f, 1'b1);
        start = 1'b0;
        drive_round(16'h0001, 16'h0000, 1'b1);
        // window already closed, draining
        repeat (2) drive_round('1, '1, 1'b0);
        finish_window("outside_window");
        repeat (3) drive_round('1, '0, 1'b0);
        idle(`VOTE_PIPE_LAT + 2);
        check_sum("after_done", vote_pkg::sum_t'(model_sum), tally);
        check_bit("after_done_busy", 1'b0, busy);
    endtask

    task automatic zero_round_window();
        open_window(0);
        finish_window("zero_rounds");
    endtask

    initial begin
        errors = 0;
        checks = 0;
        model_sum = 0;
        lfsr_state = 32'd86946;
        rst = 1'b1;
        start = 1'b0;
        rounds = '0;
        store = '0;
        core_result = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        reset_state();
        uniform_votes();
        random_votes();
        gapped_rounds();
        strobes_outside_window();
        zero_round_window();
        idle(2);
        $display("errors: %0d of %0d checks", errors, checks);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // hang guard
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
        $display("errors: %0d of %0d checks", errors, checks);
        $display("sim failed");
        $finish;
    end

endmodule

// File: test/vote_properties.sv
`timescale 1ns/1ns

module vote_properties (
    input logic                 clk,
    input logic                 rst,
    input logic                 start,
    input logic                 busy,
    input logic                 done,
    input logic                 accept,
    input logic                 clear,
    // accepted strobe pulse from the counter
    input logic                 round,
    // sequencer state, reached through the bind
    input vote_pkg::seq_state_t state
);

    // done lasts exactly one cycle
    a_done_pulse: assert property (@(posedge clk) disable iff (rst)
        done |=> !done)
        else $error("done stayed high for more than one cycle");

    // window closes only on a counted round
    a_accept_close: assert property (@(posedge clk) disable iff (rst)
        $fell(accept) |-> $past(round))
        else $error("accept fell without a counted round");

    // clear needs a start taken while idle
    a_clear_start: assert property (@(posedge clk) disable iff (rst)
        clear |-> ($past(start) && !$past(busy)))
        else $error("clear without an accepted start");

    // done comes from the drain, never mid window
    a_done_state: assert property (@(posedge clk) disable iff (rst)
        done |-> (state != vote_pkg::seq_count))
        else $error("done high while counting rounds");

endmodule

bind vote_top vote_properties u_props (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .busy   (busy),
    .done   (done),
    .accept (accept),
    .clear  (clear),
    .round  (round),
    .state  (u_seq.state)
);

// File: rtl/vote_top.sv
`timescale 1ns/1ns
`default_nettype none
`include "vote_params.svh"

module vote_top (
    input  logic                clk,
    input  logic                rst,
    // window control
    input  logic                start,
    input  vote_pkg::round_t    rounds,
    // core strobes and result bits
    input  vote_pkg::core_vec_t store,
    input  vote_pkg::core_vec_t core_result,
    // status
    output logic                busy,
    output logic                done,
    output logic                decision,
    output vote_pkg::sum_t      tally
);

    // sequencer to counter
    logic clear;
    logic accept;
    // counter to sequencer
    logic round;

    // datapath, strobe masking through accumulator
    vote_counter u_counter (
        .clk         (clk),
        .rst         (rst),
        .clear       (clear),
        .accept      (accept),
        .store       (store),
        .core_result (core_result),
        .round       (round),
        .tally       (tally)
    );

    // window control and decision latch
    // decision follows the tally's sign bit
    vote_sequencer u_seq (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .rounds   (rounds),
        .round    (round),
        .clear    (clear),
        .accept   (accept),
        .busy     (busy),
        .done     (done),
        .sign_bit (tally[`VOTE_SUM_W-1]),
        .decision (decision)
    );

endmodule

`default_nettype wire

// File: rtl/vote_sequencer.sv
`timescale 1ns/1ns
`default_nettype none
`include "vote_params.svh"

module vote_sequencer (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    // number of rounds for the window, sampled with start
    input  vote_pkg::round_t rounds,
    // one pulse per cycle with accepted strobes
    input  logic             round,
    output logic             clear,
    output logic             accept,
    output logic             busy,
    output logic             done,
    // top bit of the running tally
    input  logic             sign_bit,
    output logic             decision
);

    // drain counter sized for the pipeline latency
    localparam int DRAIN_W = $clog2(`VOTE_PIPE_LAT + 1);
    localparam logic [DRAIN_W-1:0] DRAIN_LAST = DRAIN_W'(`VOTE_PIPE_LAT - 1);

    vote_pkg::seq_state_t state;
    // latched round target
    vote_pkg::round_t target;
    // rounds seen so far in this window
    vote_pkg::round_t count;
    vote_pkg::round_t count_next;
    logic [DRAIN_W-1:0] drain_cnt;
    // last drain cycle, final tally is settled
    logic drain_end;

    assign count_next = count + 1'b1;
    assign drain_end = (state == vote_pkg::seq_drain) && (drain_cnt == DRAIN_LAST);

    // levels straight from the state
    assign accept = (state == vote_pkg::seq_count);
    assign busy = (state != vote_pkg::seq_idle);

    // round target taken with an accepted start
    always_ff @(posedge clk) begin
        if (state == vote_pkg::seq_idle && start) begin
            target <= rounds;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= vote_pkg::seq_idle;
            clear <= 1'b0;
            done <= 1'b0;
            decision <= 1'b0;
            count <= '0;
            drain_cnt <= '0;
        end else begin
            // pulses default low
            clear <= 1'b0;
            done <= 1'b0;
            case (state)
                vote_pkg::seq_idle: begin
                    // start while busy never reaches here
                    if (start) begin
                        clear <= 1'b1;
                        decision <= 1'b0;
                        count <= '0;
                        drain_cnt <= '0;
                        // zero rounds skips the window entirely
                        if (rounds == '0) begin
                            state <= vote_pkg::seq_drain;
                        end else begin
                            state <= vote_pkg::seq_count;
                        end
                    end
                end
                vote_pkg::seq_count: begin
                    if (round) begin
                        count <= count_next;
                        // last round closes the window at once
                        if (count_next == target) begin
                            drain_cnt <= '0;
                            state <= vote_pkg::seq_drain;
                        end
                    end
                end
                vote_pkg::seq_drain: begin
                    if (drain_end) begin
                        // final tally visible, take its sign
                        decision <= sign_bit;
                        done <= 1'b1;
                        state <= vote_pkg::seq_idle;
                    end else begin
                        drain_cnt <= drain_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= vote_pkg::seq_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/vote_counter.sv
`timescale 1ns/1ns
`default_nettype none
`include "vote_params.svh"

module vote_counter (
    input  logic               clk,
    input  logic               rst,
    // zeroes the tally at the start of a window
    input  logic               clear,
    // window open
    input  logic               accept,
    input  vote_pkg::core_vec_t store,
    input  vote_pkg::core_vec_t core_result,
    // any accepted strobe this cycle
    output logic               round,
    output vote_pkg::sum_t     tally
);

    // strobes outside the window are dropped here
    vote_pkg::core_vec_t store_ok;
    // per core votes after the selector stage
    vote_pkg::vote_t votes [`VOTE_CORES];
    // tree output for the round now leaving the tree
    vote_pkg::sum_t tree_total;
    // round strobe delayed to line up with tree_total
    // one bit for the selector, one per tree level
    logic [`VOTE_TREE_STAGES:0] round_dly;

    assign store_ok = store & {`VOTE_CORES{accept}};
    assign round = |store_ok;

    // one selector per core
    for (genvar k = 0; k < `VOTE_CORES; k++) begin : g_sel
        vote_selector u_sel (
            .clk        (clk),
            .rst        (rst),
            .store_bit  (store_ok[k]),
            .result_bit (core_result[k]),
            .vote       (votes[k])
        );
    end

    vote_adder_tree u_tree (
        .clk   (clk),
        .rst   (rst),
        .votes (votes),
        .total (tree_total)
    );

    // delayed round strobe, shifted every cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            round_dly <= '0;
        end else begin
            round_dly <= {round_dly[`VOTE_TREE_STAGES-1:0], round};
        end
    end

    // signed accumulator
    // clear wins over a late add, the pipe is empty by then anyway
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            tally <= '0;
        end else if (round_dly[`VOTE_TREE_STAGES]) begin
            // only cycles that carried strobes touch the tally
            tally <= tally + tree_total;
        end
    end

endmodule

`default_nettype wire

// File: rtl/vote_adder_tree.sv
`timescale 1ns/1ns
`default_nettype none
`include "vote_params.svh"

module vote_adder_tree (
    input  logic            clk,
    input  logic            rst,
    // one vote per core, sampled every cycle
    input  vote_pkg::vote_t votes [`VOTE_CORES],
    // sum of one cycle's votes, VOTE_TREE_STAGES cycles later
    output vote_pkg::sum_t  total
);

    // width of a single vote
    localparam int VOTE_W = $bits(vote_pkg::vote_t);
    // width of the root node
    // each level adds one bit of growth
    localparam int TOP_W = VOTE_W + `VOTE_TREE_STAGES;

    // one registered level per genvar
    // no stall, so every cycle's votes are their own item in flight
    for (genvar l = 0; l < `VOTE_TREE_STAGES; l++) begin : g_lvl
        // node count and width on this level
        localparam int N = `VOTE_CORES >> (l + 1);
        localparam int LW = VOTE_W + l + 1;
        // width of the level below
        localparam int PW = LW - 1;

        logic signed [LW-1:0] psum [N];

        if (l == 0) begin : g_leaf
            // first level adds raw vote pairs
            always_ff @(posedge clk) begin
                if (rst) begin
                    for (int i = 0; i < N; i++) begin
                        psum[i] <= '0;
                    end
                end else begin
                    for (int i = 0; i < N; i++) begin
                        // sign extend both votes by one bit before the add
                        psum[i] <= {votes[2*i][PW-1], votes[2*i]}
                                 + {votes[2*i+1][PW-1], votes[2*i+1]};
                    end
                end
            end
        end else begin : g_inner
            // upper levels add pairs from the level below
            always_ff @(posedge clk) begin
                if (rst) begin
                    for (int i = 0; i < N; i++) begin
                        psum[i] <= '0;
                    end
                end else begin
                    for (int i = 0; i < N; i++) begin
                        psum[i] <= {g_lvl[l-1].psum[2*i][PW-1], g_lvl[l-1].psum[2*i]}
                                 + {g_lvl[l-1].psum[2*i+1][PW-1], g_lvl[l-1].psum[2*i+1]};
                    end
                end
            end
        end
    end

    // root node, widened to tally width
    logic signed [TOP_W-1:0] root;

    assign root = g_lvl[`VOTE_TREE_STAGES-1].psum[0];

    // sign extension up to the accumulator width
    assign total = {{(`VOTE_SUM_W - TOP_W){root[TOP_W-1]}}, root};

endmodule

`default_nettype wire

// File: rtl/vote_selector.sv
`timescale 1ns/1ns
`default_nettype none

module vote_selector (
    input  logic            clk,
    input  logic            rst,
    // strobe from one core, already gated by the window
    input  logic            store_bit,
    // result bit stored along with the strobe
    input  logic            result_bit,
    // registered vote for this core
    output vote_pkg::vote_t vote
);

    // vote encodings
    localparam vote_pkg::vote_t VOTE_PLUS = 2'sb01;
    localparam vote_pkg::vote_t VOTE_MINUS = 2'sb11;
    localparam vote_pkg::vote_t VOTE_NONE = 2'sb00;

    // one cycle of latency
    always_ff @(posedge clk) begin
        if (rst) begin
            vote <= VOTE_NONE;
        end else if (store_bit) begin
            // stored 1 pushes the tally up, stored 0 pulls it down
            vote <= result_bit ? VOTE_PLUS : VOTE_MINUS;
        end else begin
            // idle core abstains
            vote <= VOTE_NONE;
        end
    end

endmodule

`default_nettype wire

// File: rtl/vote_pkg.sv
`include "vote_params.svh"

package vote_pkg;

    // one bit per core, strobes or result bits
    typedef logic [`VOTE_CORES-1:0] core_vec_t;

    // single signed vote
    // holds -1, 0 or +1
    typedef logic signed [1:0] vote_t;

    // running tally and the tree partial sums
    typedef logic signed [`VOTE_SUM_W-1:0] sum_t;

    // programmed number of rounds, unsigned
    typedef logic [`VOTE_ROUND_W-1:0] round_t;

    // round sequencer states
    typedef enum logic [1:0] {
        // waiting for start
        seq_idle,
        // window open, counting rounds
        seq_count,
        // window closed, pipeline emptying
        seq_drain
    } seq_state_t;

endpackage

// File: include/vote_params.svh
`ifndef VOTE_PARAMS_SVH
`define VOTE_PARAMS_SVH

// number of compute cores feeding the tally
`define VOTE_CORES 16

// adder tree levels, log2 of the core count
`define VOTE_TREE_STAGES 4

// signed tally width
`define VOTE_SUM_W 30

// programmed round count width
`define VOTE_ROUND_W 16

// strobe to tally latency
// selector stage, tree levels, accumulate stage
`define VOTE_PIPE_LAT (1 + `VOTE_TREE_STAGES + 1)

`endif
